// File: dv/cpu_subsystem_tb.sv
`default_nettype none

module cpu_subsystem_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS    = 256;
    localparam int AW           = $clog2(MEM_WORDS);
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int RUNS         = 6;
    // Preload, 4000 cycles of execution and the idle gap
    localparam int RUN_CYCLES   = MEM_WORDS + 4000 + 16;

    // ======================================================================
    // MIPS32 encodings, taken from the ISA manual
    // ======================================================================
    localparam logic [5:0] OPC_ADDIU = 6'h09;
    localparam logic [5:0] OPC_LW    = 6'h23;
    localparam logic [5:0] OPC_SW    = 6'h2B;
    localparam logic [5:0] OPC_BEQ   = 6'h04;
    localparam logic [5:0] OPC_BNE   = 6'h05;
    localparam logic [5:0] OPC_BLEZ  = 6'h06;
    localparam logic [5:0] FUN_ADDU  = 6'h21;
    localparam logic [5:0] FUN_SUBU  = 6'h23;
    localparam logic [5:0] FUN_AND   = 6'h24;
    localparam logic [5:0] FUN_OR    = 6'h25;
    localparam logic [5:0] FUN_SLT   = 6'h2A;
    localparam logic [5:0] FUN_JR    = 6'h08;

    localparam logic [4:0] R_ZERO = 5'd0;
    localparam logic [4:0] R_V0   = 5'd2;
    localparam logic [4:0] R_T0   = 5'd8;
    localparam logic [4:0] R_T1   = 5'd9;
    localparam logic [4:0] R_T2   = 5'd10;
    localparam logic [4:0] R_T3   = 5'd11;
    localparam logic [4:0] R_T4   = 5'd12;
    localparam logic [4:0] R_S0   = 5'd16;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        load_valid;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic        load_ready;
    logic        active;
    logic [31:0] register_v0;

    logic [31:0] image [MEM_WORDS];
    int          fill_ptr;
    logic [31:0] expected_v0;
    int          errors;
    int          runs;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    cpu_subsystem #(
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_CYCLES (2)
    ) DUT (
        .clk, .rst_n, .start, .load_valid, .load_addr, .load_data,
        .load_ready, .active, .register_v0
    );

    // ======================================================================
    // Checks
    // ======================================================================
    v0_at_halt: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(active) |-> register_v0 == expected_v0)
    else begin
        errors++;
        $display("** Error: register_v0 = 0x%08h, expected 0x%08h", register_v0, expected_v0);
    end

    idle_until_start: assert property (@(posedge clk) disable iff (!rst_n)
        !active && !start |=> !active)
    else begin
        errors++;
        $display("** Error: active = 0x%h without a start, expected 0x0", active);
    end

    load_gate: assert property (@(posedge clk) disable iff (!rst_n)
        load_ready == !active)
    else begin
        errors++;
        $display("** Error: load_ready = 0x%h, expected 0x%h", load_ready, !active);
    end

    // ======================================================================
    // Program building and reference model
    // ======================================================================
    function automatic logic [31:0] encode_itype(logic [5:0] op, logic [4:0] rs,
                                                 logic [4:0] rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encode_rtype(logic [4:0] rs, logic [4:0] rt,
                                                 logic [4:0] rd, logic [5:0] fn);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    task automatic clear_image();
        // Unused words carry their own word index
        for (int i = 0; i < MEM_WORDS; i++) begin
            image[i] = {16'hFFEE, 16'(i)};
        end
        fill_ptr = 0;
    endtask

    task automatic emit(logic [31:0] word);
        image[fill_ptr] = word;
        fill_ptr++;
    endtask

    // Instruction-level interpreter, returns v0 at the jr to 0
    function automatic logic [31:0] model_v0();
        logic [31:0] r [32];
        logic [31:0] m [MEM_WORDS];
        logic [31:0] pc_m;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] ea;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            r[i] = '0;
        end
        m = image;
        pc_m = '0;
        steps = 0;
        while (steps < 3000) begin
            w = m[pc_m[AW+1:2]];
            a = r[w[25:21]];
            b = r[w[20:16]];
            simm = {{16{w[15]}}, w[15:0]};
            ea = a + simm;
            pc_m = pc_m + 32'd4;
            steps++;
            case (w[31:26])
                OPC_ADDIU: r[w[20:16]] = ea;
                OPC_LW:    r[w[20:16]] = m[ea[AW+1:2]];
                OPC_SW:    m[ea[AW+1:2]] = b;
                OPC_BEQ:   if (a == b) pc_m = pc_m + (simm << 2);
                OPC_BNE:   if (a != b) pc_m = pc_m + (simm << 2);
                OPC_BLEZ:  if ($signed(a) <= 0) pc_m = pc_m + (simm << 2);
                6'h00: begin
                    case (w[5:0])
                        FUN_ADDU: r[w[15:11]] = a + b;
                        FUN_SUBU: r[w[15:11]] = a - b;
                        FUN_AND:  r[w[15:11]] = a & b;
                        FUN_OR:   r[w[15:11]] = a | b;
                        FUN_SLT:  r[w[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FUN_JR: begin
                            if (a == 32'd0) begin
                                return r[2];
                            end
                            pc_m = a;
                        end
                        default: ;
                    endcase
                end
                default: ;
            endcase
            r[0] = '0;
        end
        return r[2];
    endfunction

    // ======================================================================
    // Bus-level tasks, entered 2 ns after a rising edge
    // ======================================================================
    task automatic load_image();
        for (int i = 0; i < MEM_WORDS; i++) begin
            load_valid = 1'b1;
            load_addr  = 32'(i * 4);
            load_data  = image[i];
            while (!load_ready) begin
                @(posedge clk);
                #2;
            end
            @(posedge clk);
            #2;
        end
        load_valid = 1'b0;
    endtask

    task automatic run_program();
        expected_v0 = model_v0();
        load_image();
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        assert (active) else begin
            errors++;
            $display("** Error: active = 0x%h one cycle after start, expected 0x1", active);
        end
        while (active) begin
            @(posedge clk);
            #2;
        end
        runs++;
        // Short idle gap before the next preload
        repeat (4) begin
            @(posedge clk);
        end
        #2;
    endtask

    task automatic arith_program();
        logic [15:0] imm_a;
        logic [15:0] imm_b;
        logic [15:0] imm_c;
        imm_a = 16'($urandom());
        imm_b = 16'($urandom());
        imm_c = 16'($urandom());
        clear_image();
        emit(encode_itype(OPC_ADDIU, R_ZERO, R_T0, imm_a));
        emit(encode_itype(OPC_ADDIU, R_ZERO, R_T1, imm_b));
        emit(encode_itype(OPC_ADDIU, R_T1, R_T2, imm_c));
        emit(encode_rtype(R_T0, R_T1, R_T3, FUN_ADDU));
        emit(encode_rtype(R_T3, R_T2, R_T4, FUN_SUBU));
        emit(encode_rtype(R_T4, R_T0, R_T3, FUN_AND));
        emit(encode_rtype(R_T3, R_T1, R_T4, FUN_OR));
        emit(encode_rtype(R_T0, R_T1, R_T2, FUN_SLT));
        emit(encode_rtype(R_T4, R_T2, R_V0, FUN_ADDU));
        emit(encode_rtype(R_T1, R_T0, R_T2, FUN_SLT));
        emit(encode_rtype(R_V0, R_T2, R_V0, FUN_SUBU));
        emit(encode_rtype(R_ZERO, R_ZERO, R_ZERO, FUN_JR));
        run_program();
    endtask

    // Taken blez skips the increment, v0 stays at 0x70
    task automatic blez_program(logic [15:0] value);
        clear_image();
        emit(encode_itype(OPC_ADDIU, R_ZERO, R_T0, value));
        emit(encode_itype(OPC_ADDIU, R_ZERO, R_V0, 16'h0070));
        emit(encode_itype(OPC_BLEZ, R_T0, R_ZERO, 16'd1));
        emit(encode_itype(OPC_ADDIU, R_V0, R_V0, 16'd1));
        emit(encode_rtype(R_ZERO, R_ZERO, R_ZERO, FUN_JR));
        run_program();
    endtask

    task automatic compare_branch_program(logic [15:0] val_a, logic [15:0] val_b);
        clear_image();
        emit(encode_itype(OPC_ADDIU, R_ZERO, R_T0, val_a));
        emit(encode_itype(OPC_ADDIU, R_ZERO, R_T1, val_b));
        emit(encode_itype(OPC_ADDIU, R_ZERO, R_V0, 16'd0));
        emit(encode_itype(OPC_BEQ, R_T0, R_T1, 16'd1));
        emit(encode_itype(OPC_ADDIU, R_V0, R_V0, 16'h0010));
        emit(encode_itype(OPC_BNE, R_T0, R_T1, 16'd1));
        emit(encode_itype(OPC_ADDIU, R_V0, R_V0, 16'h0020));
        emit(encode_rtype(R_ZERO, R_ZERO, R_ZERO, FUN_JR));
        run_program();
    endtask

    // Stores to a data area at byte 0x200, then sums the words back
    task automatic memory_program();
        logic [15:0] val;
        clear_image();
        emit(encode_itype(OPC_ADDIU, R_ZERO, R_S0, 16'h0200));
        for (int k = 0; k < 4; k++) begin
            val = 16'($urandom());
            emit(encode_itype(OPC_ADDIU, R_ZERO, R_T0, val));
            emit(encode_itype(OPC_SW, R_S0, R_T0, 16'(4 * k)));
        end
        emit(encode_itype(OPC_ADDIU, R_ZERO, R_V0, 16'd0));
        for (int k = 0; k < 4; k++) begin
            emit(encode_itype(OPC_LW, R_S0, R_T1, 16'(4 * k)));
            emit(encode_rtype(R_V0, R_T1, R_V0, FUN_ADDU));
        end
        emit(encode_rtype(R_ZERO, R_ZERO, R_ZERO, FUN_JR));
        run_program();
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        void'($urandom(5734));
        errors      = 0;
        runs        = 0;
        rst_n       = 1'b0;
        start       = 1'b0;
        load_valid  = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        expected_v0 = '0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
        end
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        assert (!active) else begin
            errors++;
            $display("** Error: active = 0x%h after reset, expected 0x0", active);
        end
        assert (load_ready) else begin
            errors++;
            $display("** Error: load_ready = 0x%h after reset, expected 0x1", load_ready);
        end
        arith_program();
        blez_program(16'hFFFB);
        blez_program(16'h0005);
        compare_branch_program(16'h1234, 16'h1234);
        compare_branch_program(16'h1234, 16'h4321);
        memory_program();
        $display("Runs completed: %0d, errors: %0d", runs, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + 2 + RUNS * RUN_CYCLES));
        $display("Watchdog expired, a program did not halt in time");
        $display("Runs completed: %0d, errors: %0d", runs, errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: mips_cpu.f
source/mips_isa_pkg.sv
source/avalon_pkg.sv
source/fetch_unit.sv
source/load_store_unit.sv
source/avalon_arbiter.sv
source/avalon_ram.sv
source/cpu_core.sv
source/cpu_subsystem.sv
dv/cpu_subsystem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line.
# The exit status is nonzero when the build fails or the pass line is missing.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpu_subsystem_tb \
    -f mips_cpu.f &&
./obj_dir/Vcpu_subsystem_tb | tee /dev/stderr | grep -x "TEST OK" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: source/avalon_arbiter.sv
`default_nettype none

module avalon_arbiter (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              fetch_req_valid,
    output logic                                   fetch_req_ready,
    input  wire logic [31:0]                       fetch_addr,
    output logic [31:0]                            fetch_rdata,
    input  wire logic                              lsu_req_valid,
    output logic                                   lsu_req_ready,
    input  wire logic                              lsu_write,
    input  wire logic [31:0]                       lsu_addr,
    input  wire logic [31:0]                       lsu_wdata,
    output logic [31:0]                            lsu_rdata,
    output logic [avalon_pkg::ADDR_WIDTH-1:0]      address,
    output logic                                   read,
    output logic                                   write,
    output logic [avalon_pkg::DATA_WIDTH-1:0]      writedata,
    output logic [avalon_pkg::BE_WIDTH-1:0]        byteenable,
    input  wire logic                              waitrequest,
    input  wire logic [avalon_pkg::DATA_WIDTH-1:0] readdata
);
    import avalon_pkg::*;

    logic   busy_q;
    grant_e grant_q;
    grant_e last_q;
    grant_e grant_d;
    logic   lsu_owns;
    logic   fetch_owns;

    // Round robin, the requester that lost last time wins a tie
    always_comb begin
        grant_d = grant_q;
        if (fetch_req_valid && lsu_req_valid) begin
            grant_d = (last_q == GRANT_FETCH) ? GRANT_LSU : GRANT_FETCH;
        end else if (lsu_req_valid) begin
            grant_d = GRANT_LSU;
        end else if (fetch_req_valid) begin
            grant_d = GRANT_FETCH;
        end
    end

    // Grant locked from issue until waitrequest drops
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            grant_q <= GRANT_FETCH;
            last_q  <= GRANT_LSU;
        end else if (!busy_q) begin
            if (fetch_req_valid || lsu_req_valid) begin
                busy_q  <= 1'b1;
                grant_q <= grant_d;
            end
        end else if (!waitrequest) begin
            busy_q <= 1'b0;
            last_q <= grant_q;
        end
    end

    assign lsu_owns   = busy_q && (grant_q == GRANT_LSU);
    assign fetch_owns = busy_q && (grant_q == GRANT_FETCH);

    // Avalon master side
    assign read       = fetch_owns || (lsu_owns && !lsu_write);
    assign write      = lsu_owns && lsu_write;
    assign address    = lsu_owns ? lsu_addr : fetch_addr;
    assign writedata  = lsu_wdata;
    assign byteenable = BYTE_ALL;

    // Completion goes back only to the owner
    assign fetch_req_ready = fetch_owns && !waitrequest;
    assign lsu_req_ready   = lsu_owns && !waitrequest;
    assign fetch_rdata     = readdata;
    assign lsu_rdata       = readdata;

endmodule

`default_nettype wire

// File: source/avalon_pkg.sv
`default_nettype none

package avalon_pkg;

    // Bus widths of the shared master port
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int BE_WIDTH   = DATA_WIDTH / 8;

    // Only whole words are moved
    localparam logic [BE_WIDTH-1:0] BYTE_ALL = '1;

    // Current owner of the bus
    typedef enum logic {
        GRANT_FETCH = 1'b0,
        GRANT_LSU   = 1'b1
    } grant_e;

endpackage

`default_nettype wire

// File: source/avalon_ram.sv
`default_nettype none

module avalon_ram #(
    parameter int MEM_WORDS   = 256,
    parameter int WAIT_CYCLES = 1
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic [avalon_pkg::ADDR_WIDTH-1:0] address,
    input  wire logic                              read,
    input  wire logic                              write,
    input  wire logic [avalon_pkg::DATA_WIDTH-1:0] writedata,
    input  wire logic [avalon_pkg::BE_WIDTH-1:0]   byteenable,
    output logic                                   waitrequest,
    output logic [avalon_pkg::DATA_WIDTH-1:0]      readdata,
    input  wire logic                              load_valid,
    input  wire logic [31:0]                       load_addr,
    input  wire logic [31:0]                       load_data,
    output logic                                   load_ready,
    input  wire logic                              active
);
    import avalon_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);
    localparam int CW = $clog2(WAIT_CYCLES + 2);

    logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
    logic [CW-1:0]         wait_cnt;
    logic [AW-1:0]         word_idx;
    logic [AW-1:0]         load_idx;
    logic                  access;

    // Byte addresses in, word index out
    assign word_idx = address[AW+1:2];
    assign load_idx = load_addr[AW+1:2];
    assign access   = read || write;

    // ======================================================================
    // Wait state counter
    // ======================================================================
    assign waitrequest = access && (wait_cnt != CW'(WAIT_CYCLES));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (access && waitrequest) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    // Preload only while the processor is idle
    assign load_ready = !active;

    always_ff @(posedge clk) begin
        if (write && !waitrequest) begin
            for (int b = 0; b < BE_WIDTH; b++) begin
                if (byteenable[b]) begin
                    mem[word_idx][8*b +: 8] <= writedata[8*b +: 8];
                end
            end
        end else if (load_valid && load_ready) begin
            mem[load_idx] <= load_data;
        end
    end

    assign readdata = mem[word_idx];

endmodule

`default_nettype wire

// File: source/cpu_core.sv
`default_nettype none

module cpu_core (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 start,
    output logic                      active,
    output logic [31:0]               register_v0,
    output logic                      fetch_start,
    output logic                      pc_load,
    output logic [31:0]               next_pc,
    input  wire logic [31:0]          pc,
    input  wire mips_isa_pkg::instr_u instr,
    input  wire logic                 instr_valid,
    output logic                      mem_start,
    output logic                      mem_write,
    output logic [31:0]               mem_addr,
    output logic [31:0]               mem_wdata,
    input  wire logic [31:0]          mem_rdata,
    input  wire logic                 mem_done
);
    import mips_isa_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_MEM,
        S_WRITEBACK
    } state_e;

    state_e      state;
    logic [31:0] regs [32];
    logic [31:0] a_q;
    logic [31:0] b_q;
    logic [31:0] alu_q;
    logic [31:0] npc_q;

    logic [5:0]  opcode;
    logic        is_rtype;
    logic        is_jr;
    logic        is_mem;
    logic        rtype_alu;
    logic        reg_we;
    logic        taken;
    logic        halt;
    logic [4:0]  dest;
    logic [31:0] imm_sext;
    logic [31:0] op_b;
    logic [31:0] alu_res;
    logic [31:0] pc_plus4;
    alu_op_e     alu_op;

    // ======================================================================
    // Decode
    // ======================================================================
    assign opcode   = instr.i.opcode;
    assign is_rtype = (opcode == OP_RTYPE);
    assign is_jr    = is_rtype && (instr.r.funct == FN_JR);
    assign is_mem   = (opcode == OP_LW) || (opcode == OP_SW);
    assign imm_sext = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign dest     = is_rtype ? instr.r.rd : instr.i.rt;
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        alu_op    = ALU_ADD;
        rtype_alu = 1'b0;
        if (is_rtype) begin
            rtype_alu = 1'b1;
            case (instr.r.funct)
                FN_ADDU: alu_op = ALU_ADD;
                FN_SUBU: alu_op = ALU_SUB;
                FN_AND:  alu_op = ALU_AND;
                FN_OR:   alu_op = ALU_OR;
                FN_SLT:  alu_op = ALU_SLT;
                default: rtype_alu = 1'b0;
            endcase
        end
    end

    // ALU, I-type words use the immediate as second operand
    assign op_b = is_rtype ? b_q : imm_sext;

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_res = a_q - op_b;
            ALU_AND: alu_res = a_q & op_b;
            ALU_OR:  alu_res = a_q | op_b;
            ALU_SLT: alu_res = {31'd0, $signed(a_q) < $signed(op_b)};
            default: alu_res = a_q + op_b;
        endcase
    end

    // Signed branch tests, no delay slot
    assign taken = ((opcode == OP_BEQ) && (a_q == b_q))
                || ((opcode == OP_BNE) && (a_q != b_q))
                || ((opcode == OP_BLEZ) && ($signed(a_q) <= 0));
    assign halt  = is_jr && (a_q == 32'd0);

    // ======================================================================
    // Register file
    // ======================================================================
    assign reg_we = (state == S_WRITEBACK) && (dest != 5'd0)
                 && (rtype_alu || (opcode == OP_ADDIU) || (opcode == OP_LW));

    always_ff @(posedge clk) begin
        if (reg_we) begin
            regs[dest] <= (opcode == OP_LW) ? mem_rdata : alu_q;
        end
    end

    assign register_v0 = regs[REG_V0];

    // Operand and result registers
    always_ff @(posedge clk) begin
        if (state == S_DECODE) begin
            a_q <= (instr.r.rs == 5'd0) ? 32'd0 : regs[instr.r.rs];
            b_q <= (instr.r.rt == 5'd0) ? 32'd0 : regs[instr.r.rt];
        end
        if (state == S_EXECUTE) begin
            alu_q <= alu_res;
            if (taken) begin
                npc_q <= pc_plus4 + {imm_sext[29:0], 2'b00};
            end else if (is_jr) begin
                npc_q <= a_q;
            end else begin
                npc_q <= pc_plus4;
            end
        end
    end

    // ======================================================================
    // Control FSM
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= S_IDLE;
            active <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state  <= S_FETCH;
                        active <= 1'b1;
                    end
                end
                S_FETCH:   if (instr_valid) state <= S_DECODE;
                S_DECODE:  state <= S_EXECUTE;
                S_EXECUTE: state <= is_mem ? S_MEM : S_WRITEBACK;
                S_MEM:     if (mem_done) state <= S_WRITEBACK;
                S_WRITEBACK: begin
                    if (halt) begin
                        state  <= S_IDLE;
                        active <= 1'b0;
                    end else begin
                        state <= S_FETCH;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Fetch side, start reloads the reset address
    assign pc_load     = ((state == S_IDLE) && start) || (state == S_WRITEBACK);
    assign next_pc     = (state == S_IDLE) ? RESET_PC : npc_q;
    assign fetch_start = ((state == S_IDLE) && start) || ((state == S_WRITEBACK) && !halt);

    // Memory side
    assign mem_start = (state == S_EXECUTE) && is_mem;
    assign mem_write = (opcode == OP_SW);
    assign mem_addr  = alu_res;
    assign mem_wdata = b_q;

endmodule

`default_nettype wire

// File: source/cpu_subsystem.sv
`default_nettype none

module cpu_subsystem #(
    parameter int MEM_WORDS   = 256,
    parameter int WAIT_CYCLES = 1
) (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        start,
    input  wire logic        load_valid,
    input  wire logic [31:0] load_addr,
    input  wire logic [31:0] load_data,
    output logic             load_ready,
    output logic             active,
    output logic [31:0]      register_v0
);

    // Core to helpers
    logic                 fetch_start;
    logic                 pc_load;
    logic [31:0]          next_pc;
    logic [31:0]          pc;
    mips_isa_pkg::instr_u instr;
    logic                 instr_valid;
    logic                 mem_start;
    logic                 mem_write;
    logic [31:0]          mem_addr;
    logic [31:0]          mem_wdata;
    logic [31:0]          mem_rdata;
    logic                 mem_done;

    // Request channels
    logic        fetch_req_valid;
    logic        fetch_req_ready;
    logic [31:0] fetch_addr;
    logic [31:0] fetch_rdata;
    logic        lsu_req_valid;
    logic        lsu_req_ready;
    logic        lsu_write;
    logic [31:0] lsu_addr;
    logic [31:0] lsu_wdata;
    logic [31:0] lsu_rdata;

    // ======================================================================
    // Avalon bus
    // ======================================================================
    logic [avalon_pkg::ADDR_WIDTH-1:0] address;
    logic                              read;
    logic                              write;
    logic [avalon_pkg::DATA_WIDTH-1:0] writedata;
    logic [avalon_pkg::BE_WIDTH-1:0]   byteenable;
    logic                              waitrequest;
    logic [avalon_pkg::DATA_WIDTH-1:0] readdata;

    cpu_core u_core (
        .clk, .rst_n, .start, .active, .register_v0,
        .fetch_start, .pc_load, .next_pc, .pc, .instr, .instr_valid,
        .mem_start, .mem_write, .mem_addr, .mem_wdata, .mem_rdata, .mem_done
    );

    fetch_unit u_fetch (
        .clk, .rst_n, .fetch_start, .pc_load, .next_pc, .pc, .instr, .instr_valid,
        .fetch_req_valid, .fetch_req_ready, .fetch_addr, .fetch_rdata
    );

    load_store_unit u_lsu (
        .clk, .rst_n, .mem_start, .mem_write, .mem_addr, .mem_wdata,
        .mem_rdata, .mem_done,
        .lsu_req_valid, .lsu_write, .lsu_addr, .lsu_wdata, .lsu_req_ready, .lsu_rdata
    );

    avalon_arbiter u_arbiter (
        .clk, .rst_n,
        .fetch_req_valid, .fetch_req_ready, .fetch_addr, .fetch_rdata,
        .lsu_req_valid, .lsu_req_ready, .lsu_write, .lsu_addr, .lsu_wdata, .lsu_rdata,
        .address, .read, .write, .writedata, .byteenable, .waitrequest, .readdata
    );

    avalon_ram #(
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_ram (
        .clk, .rst_n,
        .address, .read, .write, .writedata, .byteenable, .waitrequest, .readdata,
        .load_valid, .load_addr, .load_data, .load_ready, .active
    );

endmodule

`default_nettype wire

// File: source/fetch_unit.sv
`default_nettype none

module fetch_unit (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                fetch_start,
    input  wire logic                pc_load,
    input  wire logic [31:0]         next_pc,
    output logic [31:0]              pc,
    output mips_isa_pkg::instr_u     instr,
    output logic                     instr_valid,
    output logic                     fetch_req_valid,
    input  wire logic                fetch_req_ready,
    output logic [31:0]              fetch_addr,
    input  wire logic [31:0]         fetch_rdata
);
    import mips_isa_pkg::*;

    logic fetch_done;

    assign fetch_done = fetch_req_valid && fetch_req_ready;

    // PC stays put for the whole read, so it can drive the address directly
    assign fetch_addr = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (pc_load) begin
            pc <= next_pc;
        end
    end

    // One outstanding read per fetch_start
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_req_valid <= 1'b0;
            instr_valid     <= 1'b0;
        end else begin
            instr_valid <= fetch_done;
            if (fetch_start) begin
                fetch_req_valid <= 1'b1;
            end else if (fetch_done) begin
                fetch_req_valid <= 1'b0;
            end
        end
    end

    // Instruction word held until the next fetch returns
    always_ff @(posedge clk) begin
        if (fetch_done) begin
            instr <= fetch_rdata;
        end
    end

endmodule

`default_nettype wire

// File: source/load_store_unit.sv
`default_nettype none

module load_store_unit (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        mem_start,
    input  wire logic        mem_write,
    input  wire logic [31:0] mem_addr,
    input  wire logic [31:0] mem_wdata,
    output logic [31:0]      mem_rdata,
    output logic             mem_done,
    output logic             lsu_req_valid,
    output logic             lsu_write,
    output logic [31:0]      lsu_addr,
    output logic [31:0]      lsu_wdata,
    input  wire logic        lsu_req_ready,
    input  wire logic [31:0] lsu_rdata
);

    logic xfer_done;

    assign xfer_done = lsu_req_valid && lsu_req_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lsu_req_valid <= 1'b0;
            mem_done      <= 1'b0;
        end else begin
            mem_done <= xfer_done;
            if (mem_start) begin
                lsu_req_valid <= 1'b1;
            end else if (xfer_done) begin
                lsu_req_valid <= 1'b0;
            end
        end
    end

    // Request fields, frozen until the channel accepts them
    always_ff @(posedge clk) begin
        if (mem_start) begin
            lsu_write <= mem_write;
            lsu_addr  <= mem_addr;
            lsu_wdata <= mem_wdata;
        end
    end

    // Load data, kept for the core's writeback
    always_ff @(posedge clk) begin
        if (xfer_done && !lsu_write) begin
            mem_rdata <= lsu_rdata;
        end
    end

endmodule

`default_nettype wire

// File: source/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    // Execution starts here after every start pulse
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    // ======================================================================
    // Primary opcodes
    // ======================================================================
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2B;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_BLEZ  = 6'h06;

    // Function field of R-type words
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2A;
    localparam logic [5:0] FN_JR   = 6'h08;

    // Result register brought out of the core
    localparam logic [4:0] REG_V0 = 5'd2;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    // ======================================================================
    // Instruction word, seen as I-type or R-type
    // ======================================================================
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } itype_t;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rtype_t;

    typedef union packed {
        itype_t i;
        rtype_t r;
    } instr_u;

endpackage

`default_nettype wire
